// ==== files.f ====
hw/a2card_pkg.sv
hw/power_on_timer.sv
hw/bus_strobe_sync.sv
hw/card_response_arbiter.sv
hw/audio_mixer.sv
hw/scanline_dimmer.sv
hw/a2card_top.sv
verif/a2card_properties.sv
verif/a2card_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the a2card testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module a2card_tb -Mdir obj_dir -f files.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Va2card_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1

// ==== verif/a2card_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module a2card_tb;

    import a2card_pkg::*;

    localparam int TB_HEARTBEAT_CYCLES = 16;
    localparam int NUM_ROWS            = 32;
    localparam int HOLD_CYCLES         = 8;
    localparam int NUM_STROBES         = 7;

    // Full periods per Apple clock
    // Distinct counts expose a strobe wired to the wrong clock
    localparam int PHI1_PERIODS = 6;
    localparam int Q3_PERIODS   = 4;
    localparam int C7M_PERIODS  = 3;

    // Read enables and interrupts are ordered {mb, ssp, ssc}
    typedef struct packed {
        logic [2:0]            rd;
        logic [2:0]            irq_n;
        logic [BYTE_W-1:0]     ssc_data;
        logic [BYTE_W-1:0]     ssp_data;
        logic [BYTE_W-1:0]     mb_data;
        logic [BYTE_W-1:0]     bus_data;
        logic [SAMPLE_W-1:0]   ssp_audio;
        logic [MB_AUDIO_W-1:0] mb_audio_l;
        logic [MB_AUDIO_W-1:0] mb_audio_r;
        logic                  speaker;
        logic                  sl_en;
        logic [SCREEN_Y_W-1:0] screen_y;
        logic [RGB_W-1:0]      red;
        logic [RGB_W-1:0]      green;
        logic [RGB_W-1:0]      blue;
        logic [BYTE_W-1:0]     exp_data;
        logic                  exp_dir;
        logic                  exp_irq_n;
        logic [SAMPLE_W-1:0]   exp_l;
        logic [SAMPLE_W-1:0]   exp_r;
        logic [RGB_W-1:0]      exp_red;
        logic [RGB_W-1:0]      exp_green;
        logic [RGB_W-1:0]      exp_blue;
    } row_t;

    logic clk_pixel_w;
    logic rst_n_i;
    logic a2_reset_n_i;
    logic device_reset_n_o;
    logic system_reset_n_o;
    logic heartbeat_o;
    logic a2_phi1_i;
    logic a2_q3_i;
    logic a2_7m_i;
    logic phi1_o;
    logic phi0_o;
    logic phi1_rise_o;
    logic phi1_fall_o;
    logic q3_rise_o;
    logic q3_fall_o;
    logic c7m_rise_o;
    logic c7m_fall_o;
    logic c14m_tick_o;
    logic ssc_rd_i;
    logic ssp_rd_i;
    logic mb_rd_i;
    logic [BYTE_W-1:0]     ssc_data_i;
    logic [BYTE_W-1:0]     ssp_data_i;
    logic [BYTE_W-1:0]     mb_data_i;
    logic [BYTE_W-1:0]     bus_data_i;
    logic ssc_irq_n_i;
    logic ssp_irq_n_i;
    logic mb_irq_n_i;
    logic [BYTE_W-1:0]     data_o;
    logic a2_d_dir_o;
    logic a2_irq_n_o;
    logic [SAMPLE_W-1:0]   ssp_audio_i;
    logic [MB_AUDIO_W-1:0] mb_audio_l_i;
    logic [MB_AUDIO_W-1:0] mb_audio_r_i;
    logic speaker_i;
    logic [SAMPLE_W-1:0]   audio_l_o;
    logic [SAMPLE_W-1:0]   audio_r_o;
    logic scanlines_en_i;
    logic [SCREEN_Y_W-1:0] screen_y_i;
    logic [RGB_W-1:0]      r_i;
    logic [RGB_W-1:0]      g_i;
    logic [RGB_W-1:0]      b_i;
    logic [RGB_W-1:0]      r_o;
    logic [RGB_W-1:0]      g_o;
    logic [RGB_W-1:0]      b_o;

    logic [NUM_STROBES-1:0] strobes_w;
    logic                   strobe_count_en;
    int                     strobe_cnt [NUM_STROBES];
    string                  strobe_names [NUM_STROBES] = '{"phi1_rise_o", "phi1_fall_o",
        "q3_rise_o", "q3_fall_o", "c7m_rise_o", "c7m_fall_o", "c14m_tick_o"};

    row_t table_rows [NUM_ROWS];
    int   error_count;
    int   test_base_errors;
    int   tests_passed;
    int   tests_failed;

    a2card_top #(
        .HEARTBEAT_CYCLES(TB_HEARTBEAT_CYCLES)
    ) i_a2card_top (.*);

    assign strobes_w = {c14m_tick_o, c7m_fall_o, c7m_rise_o, q3_fall_o, q3_rise_o,
                        phi1_fall_o, phi1_rise_o};

    initial begin
        clk_pixel_w = 1'b0;
        forever #20 clk_pixel_w = ~clk_pixel_w;
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", what, got, exp);
        error_count++;
    endtask

    task automatic flag_failure(input string what);
        $display("ERROR %s", what);
        error_count++;
    endtask

    task automatic start_test();
        test_base_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - test_base_errors;
        if (errs == 0) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s (%0d errors)", name, errs);
            tests_failed++;
        end
    endtask

    // Highest priority responder or else the latched bus byte
    function automatic logic [BYTE_W-1:0] pick_byte(input row_t row);
        if (row.rd[0]) return row.ssc_data;
        if (row.rd[1]) return row.ssp_data;
        if (row.rd[2]) return row.mb_data;
        return row.bus_data;
    endfunction

    // Mockingboard weighs 32 and the speaker bit 8192 before the 16-bit wrap
    function automatic logic [SAMPLE_W-1:0] mixed_sample(input logic [SAMPLE_W-1:0] spr,
                                                         input logic [MB_AUDIO_W-1:0] mb,
                                                         input logic spk);
        int sum;
        sum = int'(spr) + int'(mb) * 32 + (spk ? 8192 : 0);
        return SAMPLE_W'(sum % 65536);
    endfunction

    function automatic logic [RGB_W-1:0] dimmed(input logic [RGB_W-1:0] c, input logic en,
                                                input logic [SCREEN_Y_W-1:0] y);
        if (en && y[0]) return c / 8'd2;
        return c;
    endfunction

    // Strobes seen after a number of level changes on each clock, starting low
    function automatic int expected_strobes(input int k, input int phi1_chg,
                                            input int q3_chg, input int c7m_chg);
        int chg;
        case (k / 2)
            0:       chg = phi1_chg;
            1:       chg = q3_chg;
            default: chg = c7m_chg;
        endcase
        // Both 7M edges count toward the 14M tick
        if (k == NUM_STROBES - 1) return chg;
        if (k % 2 == 0) return (chg + 1) / 2;
        return chg / 2;
    endfunction

    task automatic compare_strobe_counts(input int phi1_chg, input int q3_chg,
                                         input int c7m_chg);
        int exp_cnt;
        for (int k = 0; k < NUM_STROBES; k++) begin
            exp_cnt = expected_strobes(k, phi1_chg, q3_chg, c7m_chg);
            if (strobe_cnt[k] != exp_cnt) begin
                report_mismatch($sformatf("%s count", strobe_names[k]), strobe_cnt[k],
                                exp_cnt);
            end
        end
    endtask

    function automatic void build_table();
        row_t row;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row.rd          = 3'(i);
            row.irq_n       = 3'(i >> 2);
            row.ssc_data    = BYTE_W'($urandom);
            row.ssp_data    = BYTE_W'($urandom);
            row.mb_data     = BYTE_W'($urandom);
            row.bus_data    = BYTE_W'($urandom);
            row.ssp_audio   = SAMPLE_W'($urandom);
            row.mb_audio_l  = MB_AUDIO_W'($urandom);
            row.mb_audio_r  = MB_AUDIO_W'($urandom);
            row.speaker     = 1'($urandom);
            row.sl_en       = i[1];
            row.screen_y    = SCREEN_Y_W'($urandom);
            row.screen_y[0] = i[0];
            row.red         = RGB_W'($urandom);
            row.green       = RGB_W'($urandom);
            row.blue        = RGB_W'($urandom);
            row.exp_data    = pick_byte(row);
            row.exp_dir     = |row.rd;
            row.exp_irq_n   = &row.irq_n;
            row.exp_l       = mixed_sample(row.ssp_audio, row.mb_audio_l, row.speaker);
            row.exp_r       = mixed_sample(row.ssp_audio, row.mb_audio_r, row.speaker);
            row.exp_red     = dimmed(row.red, row.sl_en, row.screen_y);
            row.exp_green   = dimmed(row.green, row.sl_en, row.screen_y);
            row.exp_blue    = dimmed(row.blue, row.sl_en, row.screen_y);
            table_rows[i]   = row;
        end
    endfunction

    task automatic apply_row(input row_t row);
        ssc_rd_i       = row.rd[0];
        ssp_rd_i       = row.rd[1];
        mb_rd_i        = row.rd[2];
        ssc_irq_n_i    = row.irq_n[0];
        ssp_irq_n_i    = row.irq_n[1];
        mb_irq_n_i     = row.irq_n[2];
        ssc_data_i     = row.ssc_data;
        ssp_data_i     = row.ssp_data;
        mb_data_i      = row.mb_data;
        bus_data_i     = row.bus_data;
        ssp_audio_i    = row.ssp_audio;
        mb_audio_l_i   = row.mb_audio_l;
        mb_audio_r_i   = row.mb_audio_r;
        speaker_i      = row.speaker;
        scanlines_en_i = row.sl_en;
        screen_y_i     = row.screen_y;
        r_i            = row.red;
        g_i            = row.green;
        b_i            = row.blue;
    endtask

    // Strobes and phi0 change only on the rising edge
    always @(negedge clk_pixel_w) begin
        if (strobe_count_en) begin
            for (int k = 0; k < NUM_STROBES; k++) begin
                strobe_cnt[k] += int'(strobes_w[k]);
            end
            if (phi0_o !== ~phi1_o) begin
                report_mismatch("phi0_o", 32'(phi0_o), 32'(~phi1_o));
            end
        end
    end

    task automatic check_power_on();
        int   release_cyc;
        int   toggles;
        logic last_hb;
        start_test();
        release_cyc = 0;
        toggles     = 0;
        last_hb     = heartbeat_o;
        if (device_reset_n_o !== 1'b0) begin
            report_mismatch("device_reset_n_o", 32'(device_reset_n_o), 32'h0);
        end
        if (heartbeat_o !== 1'b0) begin
            report_mismatch("heartbeat_o", 32'(heartbeat_o), 32'h0);
        end
        for (int cyc = 1; cyc <= 2 * TB_HEARTBEAT_CYCLES + 4 && toggles < 2; cyc++) begin
            @(negedge clk_pixel_w);
            if (device_reset_n_o && release_cyc == 0) begin
                release_cyc = cyc;
            end
            // Mixer stays silent while the card is held in reset
            if (!device_reset_n_o && audio_l_o !== '0) begin
                report_mismatch("audio_l_o in device reset", 32'(audio_l_o), 32'h0);
            end
            if (!device_reset_n_o && audio_r_o !== '0) begin
                report_mismatch("audio_r_o in device reset", 32'(audio_r_o), 32'h0);
            end
            if (heartbeat_o !== last_hb) begin
                toggles++;
                last_hb = heartbeat_o;
            end
        end
        if (release_cyc == 0 || release_cyc > TB_HEARTBEAT_CYCLES + 2) begin
            flag_failure("timeout, device reset was not released in time");
        end else if (release_cyc < TB_HEARTBEAT_CYCLES) begin
            flag_failure($sformatf("device reset released early, after %0d cycles",
                                   release_cyc));
        end
        if (toggles < 2) begin
            flag_failure("timeout waiting for two heartbeat toggles");
        end
        if (device_reset_n_o !== 1'b1) begin
            report_mismatch("device_reset_n_o", 32'(device_reset_n_o), 32'h1);
        end
        finish_test("power_on_timer");
    endtask

    task automatic toggle_system_reset();
        start_test();
        @(negedge clk_pixel_w);
        a2_reset_n_i = 1'b0;
        @(posedge clk_pixel_w);
        if (system_reset_n_o !== 1'b0) begin
            report_mismatch("system_reset_n_o", 32'(system_reset_n_o), 32'h0);
        end
        @(negedge clk_pixel_w);
        a2_reset_n_i = 1'b1;
        @(posedge clk_pixel_w);
        if (system_reset_n_o !== 1'b1) begin
            report_mismatch("system_reset_n_o", 32'(system_reset_n_o), 32'h1);
        end
        finish_test("system_reset");
    endtask

    task automatic count_strobes();
        start_test();
        for (int k = 0; k < NUM_STROBES; k++) begin
            strobe_cnt[k] = 0;
        end
        strobe_count_en = 1'b1;
        for (int p = 0; p < 2 * PHI1_PERIODS; p++) begin
            @(negedge clk_pixel_w);
            a2_phi1_i = ~a2_phi1_i;
            if (p < 2 * Q3_PERIODS) begin
                a2_q3_i = ~a2_q3_i;
            end
            if (p < 2 * C7M_PERIODS) begin
                a2_7m_i = ~a2_7m_i;
            end
            repeat (HOLD_CYCLES - 1) @(negedge clk_pixel_w);
            if (phi1_o !== a2_phi1_i) begin
                report_mismatch("phi1_o", 32'(phi1_o), 32'(a2_phi1_i));
            end
            // One change in, so only the rise strobes have fired
            if (p == 0) begin
                compare_strobe_counts(1, 1, 1);
            end
        end
        strobe_count_en = 1'b0;
        compare_strobe_counts(2 * PHI1_PERIODS, 2 * Q3_PERIODS, 2 * C7M_PERIODS);
        finish_test("bus_strobe_sync");
    endtask

    // Selects 0 arbiter data, 1 IRQ merge, 2 audio, 3 scanlines
    task automatic play_table(input int sel, input string name);
        row_t row;
        start_test();
        @(negedge clk_pixel_w);
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = table_rows[i];
            apply_row(row);
            @(posedge clk_pixel_w);
            if (sel == 0 && data_o !== row.exp_data) begin
                report_mismatch($sformatf("data_o row %0d", i), 32'(data_o),
                                32'(row.exp_data));
            end
            if (sel == 0 && a2_d_dir_o !== row.exp_dir) begin
                report_mismatch($sformatf("a2_d_dir_o row %0d", i), 32'(a2_d_dir_o),
                                32'(row.exp_dir));
            end
            if (sel == 1 && a2_irq_n_o !== row.exp_irq_n) begin
                report_mismatch($sformatf("a2_irq_n_o row %0d", i), 32'(a2_irq_n_o),
                                32'(row.exp_irq_n));
            end
            @(negedge clk_pixel_w);
            if (sel == 2 && audio_l_o !== row.exp_l) begin
                report_mismatch($sformatf("audio_l_o row %0d", i), 32'(audio_l_o),
                                32'(row.exp_l));
            end
            if (sel == 2 && audio_r_o !== row.exp_r) begin
                report_mismatch($sformatf("audio_r_o row %0d", i), 32'(audio_r_o),
                                32'(row.exp_r));
            end
            if (sel == 3 && r_o !== row.exp_red) begin
                report_mismatch($sformatf("r_o row %0d", i), 32'(r_o), 32'(row.exp_red));
            end
            if (sel == 3 && g_o !== row.exp_green) begin
                report_mismatch($sformatf("g_o row %0d", i), 32'(g_o), 32'(row.exp_green));
            end
            if (sel == 3 && b_o !== row.exp_blue) begin
                report_mismatch($sformatf("b_o row %0d", i), 32'(b_o), 32'(row.exp_blue));
            end
        end
        finish_test(name);
    endtask

    initial begin
        void'($urandom(70));
        error_count      = 0;
        test_base_errors = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        strobe_count_en  = 1'b0;
        rst_n_i          = 1'b0;
        a2_reset_n_i     = 1'b1;
        a2_phi1_i        = 1'b0;
        a2_q3_i          = 1'b0;
        a2_7m_i          = 1'b0;
        build_table();
        apply_row(table_rows[0]);
        // Speaker on so the mixer would be audible if it ignored device reset
        speaker_i        = 1'b1;

        repeat (10) @(posedge clk_pixel_w);
        @(negedge clk_pixel_w);
        rst_n_i = 1'b1;

        check_power_on();
        toggle_system_reset();
        count_strobes();
        play_table(0, "card_response_arbiter");
        play_table(1, "irq_merge");
        play_table(2, "audio_mixer");
        play_table(3, "scanline_dimmer");

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/a2card_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module a2card_properties (
    input wire clk_pixel_w,
    input wire rst_n_i,
    input wire phi1_rise_i,
    input wire phi1_fall_i,
    input wire q3_rise_i,
    input wire q3_fall_i,
    input wire c7m_rise_i,
    input wire c7m_fall_i,
    input wire ssc_rd_i,
    input wire ssp_rd_i,
    input wire mb_rd_i,
    input wire a2_d_dir_i
);

    logic [2:0] rise_w;
    logic [2:0] fall_w;
    logic [5:0] strobe_w;

    assign rise_w   = {c7m_rise_i, q3_rise_i, phi1_rise_i};
    assign fall_w   = {c7m_fall_i, q3_fall_i, phi1_fall_i};
    assign strobe_w = {fall_w, rise_w};

    // No strobe may stay high on two clocks in a row
    a_strobe_single_cycle: assert property (@(posedge clk_pixel_w) disable iff (!rst_n_i)
        (strobe_w & $past(strobe_w)) == 6'b0)
        else $error("edge strobe held longer than one cycle");

    // A synchronized level cannot rise and fall at once
    a_rise_fall_exclusive: assert property (@(posedge clk_pixel_w) disable iff (!rst_n_i)
        (rise_w & fall_w) == 3'b0)
        else $error("rise and fall strobes high together");

    a_dir_needs_read: assert property (@(posedge clk_pixel_w) disable iff (!rst_n_i)
        a2_d_dir_i |-> (ssc_rd_i || ssp_rd_i || mb_rd_i))
        else $error("bus driven toward the Apple II with no card reading");

endmodule

bind a2card_top a2card_properties i_a2card_properties (
    .clk_pixel_w(clk_pixel_w),
    .rst_n_i    (rst_n_i),
    .phi1_rise_i(phi1_rise_o),
    .phi1_fall_i(phi1_fall_o),
    .q3_rise_i  (q3_rise_o),
    .q3_fall_i  (q3_fall_o),
    .c7m_rise_i (c7m_rise_o),
    .c7m_fall_i (c7m_fall_o),
    .ssc_rd_i   (ssc_rd_i),
    .ssp_rd_i   (ssp_rd_i),
    .mb_rd_i    (mb_rd_i),
    .a2_d_dir_i (a2_d_dir_o)
);

`default_nettype wire

// ==== hw/a2card_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module a2card_top #(
    parameter int HEARTBEAT_CYCLES    = 5_000_000,
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1
) (
    input  wire                              clk_pixel_w,
    input  wire                              rst_n_i,

    // Reset and heartbeat
    input  wire                              a2_reset_n_i,
    output logic                             device_reset_n_o,
    output logic                             system_reset_n_o,
    output logic                             heartbeat_o,

    // Apple II clocks
    input  wire                              a2_phi1_i,
    input  wire                              a2_q3_i,
    input  wire                              a2_7m_i,
    output logic                             phi1_o,
    output logic                             phi0_o,
    output logic                             phi1_rise_o,
    output logic                             phi1_fall_o,
    output logic                             q3_rise_o,
    output logic                             q3_fall_o,
    output logic                             c7m_rise_o,
    output logic                             c7m_fall_o,
    output logic                             c14m_tick_o,

    // Card read responses and interrupts
    input  wire                              ssc_rd_i,
    input  wire                              ssp_rd_i,
    input  wire                              mb_rd_i,
    input  wire  [a2card_pkg::BYTE_W-1:0]     ssc_data_i,
    input  wire  [a2card_pkg::BYTE_W-1:0]     ssp_data_i,
    input  wire  [a2card_pkg::BYTE_W-1:0]     mb_data_i,
    input  wire  [a2card_pkg::BYTE_W-1:0]     bus_data_i,
    input  wire                              ssc_irq_n_i,
    input  wire                              ssp_irq_n_i,
    input  wire                              mb_irq_n_i,
    output logic [a2card_pkg::BYTE_W-1:0]     data_o,
    output logic                             a2_d_dir_o,
    output logic                             a2_irq_n_o,

    // Audio sources and mixed samples
    input  wire  [a2card_pkg::SAMPLE_W-1:0]   ssp_audio_i,
    input  wire  [a2card_pkg::MB_AUDIO_W-1:0] mb_audio_l_i,
    input  wire  [a2card_pkg::MB_AUDIO_W-1:0] mb_audio_r_i,
    input  wire                              speaker_i,
    output logic [a2card_pkg::SAMPLE_W-1:0]   audio_l_o,
    output logic [a2card_pkg::SAMPLE_W-1:0]   audio_r_o,

    // Pixel stream
    input  wire                              scanlines_en_i,
    input  wire  [a2card_pkg::SCREEN_Y_W-1:0] screen_y_i,
    input  wire  [a2card_pkg::RGB_W-1:0]      r_i,
    input  wire  [a2card_pkg::RGB_W-1:0]      g_i,
    input  wire  [a2card_pkg::RGB_W-1:0]      b_i,
    output logic [a2card_pkg::RGB_W-1:0]      r_o,
    output logic [a2card_pkg::RGB_W-1:0]      g_o,
    output logic [a2card_pkg::RGB_W-1:0]      b_o
);

    logic device_reset_n_w;

    power_on_timer #(
        .HEARTBEAT_CYCLES(HEARTBEAT_CYCLES)
    ) i_power_on_timer (
        .clk_pixel_w     (clk_pixel_w),
        .rst_n_i         (rst_n_i),
        .a2_reset_n_i    (a2_reset_n_i),
        .device_reset_n_o(device_reset_n_w),
        .system_reset_n_o(system_reset_n_o),
        .heartbeat_o     (heartbeat_o)
    );

    assign device_reset_n_o = device_reset_n_w;

    bus_strobe_sync i_bus_strobe_sync (
        .clk_pixel_w(clk_pixel_w),
        .rst_n_i    (rst_n_i),
        .a2_phi1_i  (a2_phi1_i),
        .a2_q3_i    (a2_q3_i),
        .a2_7m_i    (a2_7m_i),
        .phi1_o     (phi1_o),
        .phi0_o     (phi0_o),
        .phi1_rise_o(phi1_rise_o),
        .phi1_fall_o(phi1_fall_o),
        .q3_rise_o  (q3_rise_o),
        .q3_fall_o  (q3_fall_o),
        .c7m_rise_o (c7m_rise_o),
        .c7m_fall_o (c7m_fall_o),
        .c14m_tick_o(c14m_tick_o)
    );

    // a2_d_dir_o doubles as the data buffer enable
    card_response_arbiter #(
        .IRQ_OUT_ENABLE     (IRQ_OUT_ENABLE),
        .BUS_DATA_OUT_ENABLE(BUS_DATA_OUT_ENABLE)
    ) i_card_response_arbiter (
        .ssc_rd_i   (ssc_rd_i),
        .ssp_rd_i   (ssp_rd_i),
        .mb_rd_i    (mb_rd_i),
        .ssc_data_i (ssc_data_i),
        .ssp_data_i (ssp_data_i),
        .mb_data_i  (mb_data_i),
        .bus_data_i (bus_data_i),
        .ssc_irq_n_i(ssc_irq_n_i),
        .ssp_irq_n_i(ssp_irq_n_i),
        .mb_irq_n_i (mb_irq_n_i),
        .data_o     (data_o),
        .a2_d_dir_o (a2_d_dir_o),
        .a2_irq_n_o (a2_irq_n_o)
    );

    audio_mixer i_audio_mixer (
        .clk_pixel_w     (clk_pixel_w),
        .rst_n_i         (rst_n_i),
        .device_reset_n_i(device_reset_n_w),
        .ssp_audio_i     (ssp_audio_i),
        .mb_audio_l_i    (mb_audio_l_i),
        .mb_audio_r_i    (mb_audio_r_i),
        .speaker_i       (speaker_i),
        .audio_l_o       (audio_l_o),
        .audio_r_o       (audio_r_o)
    );

    scanline_dimmer i_scanline_dimmer (
        .clk_pixel_w     (clk_pixel_w),
        .rst_n_i         (rst_n_i),
        .device_reset_n_i(device_reset_n_w),
        .scanlines_en_i  (scanlines_en_i),
        .screen_y_i      (screen_y_i),
        .r_i             (r_i),
        .g_i             (g_i),
        .b_i             (b_i),
        .r_o             (r_o),
        .g_o             (g_o),
        .b_o             (b_o)
    );

endmodule

`default_nettype wire

// ==== hw/scanline_dimmer.sv ====
`timescale 1ns/100ps
`default_nettype none

module scanline_dimmer (
    input  wire                              clk_pixel_w,
    input  wire                              rst_n_i,
    input  wire                              device_reset_n_i,
    input  wire                              scanlines_en_i,
    input  wire  [a2card_pkg::SCREEN_Y_W-1:0] screen_y_i,
    input  wire  [a2card_pkg::RGB_W-1:0]      r_i,
    input  wire  [a2card_pkg::RGB_W-1:0]      g_i,
    input  wire  [a2card_pkg::RGB_W-1:0]      b_i,
    output logic [a2card_pkg::RGB_W-1:0]      r_o,
    output logic [a2card_pkg::RGB_W-1:0]      g_o,
    output logic [a2card_pkg::RGB_W-1:0]      b_o
);

    import a2card_pkg::*;

    logic dim_w;

    // Half brightness on dimmed lines
    function automatic logic [RGB_W-1:0] shade(input logic [RGB_W-1:0] c, input logic dim);
        shade = dim ? (c >> 1) : c;
    endfunction

    // Odd lines get dimmed, the classic CRT look
    assign dim_w = scanlines_en_i && screen_y_i[0];

    always_ff @(posedge clk_pixel_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            r_o <= '0;
            g_o <= '0;
            b_o <= '0;
        end else if (!device_reset_n_i) begin
            r_o <= '0;
            g_o <= '0;
            b_o <= '0;
        end else begin
            r_o <= shade(r_i, dim_w);
            g_o <= shade(g_i, dim_w);
            b_o <= shade(b_i, dim_w);
        end
    end

endmodule

`default_nettype wire

// ==== hw/audio_mixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module audio_mixer (
    input  wire                              clk_pixel_w,
    input  wire                              rst_n_i,
    input  wire                              device_reset_n_i,
    input  wire  [a2card_pkg::SAMPLE_W-1:0]   ssp_audio_i,
    input  wire  [a2card_pkg::MB_AUDIO_W-1:0] mb_audio_l_i,
    input  wire  [a2card_pkg::MB_AUDIO_W-1:0] mb_audio_r_i,
    input  wire                              speaker_i,
    output logic [a2card_pkg::SAMPLE_W-1:0]   audio_l_o,
    output logic [a2card_pkg::SAMPLE_W-1:0]   audio_r_o
);

    import a2card_pkg::*;

    logic [SAMPLE_W-1:0] speaker_term_w;
    logic [SAMPLE_W-1:0] mix_l_w;
    logic [SAMPLE_W-1:0] mix_r_w;

    // Sum of one channel, carries out of bit 15 are dropped
    function automatic logic [SAMPLE_W-1:0] mix_channel(
        input logic [SAMPLE_W-1:0]   sprite,
        input logic [MB_AUDIO_W-1:0] mb,
        input logic [SAMPLE_W-1:0]   speaker
    );
        logic [SAMPLE_W-1:0] mb_scaled;
        mb_scaled   = SAMPLE_W'(mb) << MB_SHIFT;
        mix_channel = sprite + mb_scaled + speaker;
    endfunction

    // Speaker is a single bit, it lands near the top of the range
    assign speaker_term_w = SAMPLE_W'(speaker_i) << SPEAKER_SHIFT;

    assign mix_l_w = mix_channel(ssp_audio_i, mb_audio_l_i, speaker_term_w);
    assign mix_r_w = mix_channel(ssp_audio_i, mb_audio_r_i, speaker_term_w);

    always_ff @(posedge clk_pixel_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else if (!device_reset_n_i) begin
            // Silence until the card is out of reset
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= mix_l_w;
            audio_r_o <= mix_r_w;
        end
    end

endmodule

`default_nettype wire

// ==== hw/card_response_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module card_response_arbiter #(
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1
) (
    input  wire                          ssc_rd_i,
    input  wire                          ssp_rd_i,
    input  wire                          mb_rd_i,
    input  wire  [a2card_pkg::BYTE_W-1:0] ssc_data_i,
    input  wire  [a2card_pkg::BYTE_W-1:0] ssp_data_i,
    input  wire  [a2card_pkg::BYTE_W-1:0] mb_data_i,
    input  wire  [a2card_pkg::BYTE_W-1:0] bus_data_i,
    input  wire                          ssc_irq_n_i,
    input  wire                          ssp_irq_n_i,
    input  wire                          mb_irq_n_i,
    output logic [a2card_pkg::BYTE_W-1:0] data_o,
    output logic                         a2_d_dir_o,
    output logic                         a2_irq_n_o
);

    import a2card_pkg::*;

    card_source_e src_sel_w;
    logic         card_rd_w;
    logic         irq_merged_n_w;

    // Fixed priority, serial card wins over sprite, sprite over Mockingboard
    always_comb begin
        if (ssc_rd_i) begin
            src_sel_w = SRC_SERIAL;
        end else if (ssp_rd_i) begin
            src_sel_w = SRC_SPRITE;
        end else if (mb_rd_i) begin
            src_sel_w = SRC_MOCKINGBOARD;
        end else begin
            src_sel_w = SRC_NONE;
        end
    end

    always_comb begin
        case (src_sel_w)
            SRC_SERIAL:       data_o = ssc_data_i;
            SRC_SPRITE:       data_o = ssp_data_i;
            SRC_MOCKINGBOARD: data_o = mb_data_i;
            // Nobody answers, echo the latched bus byte
            default:          data_o = bus_data_i;
        endcase
    end

    assign card_rd_w = (src_sel_w != SRC_NONE);

    // High turns the level shifter toward the Apple bus
    assign a2_d_dir_o = BUS_DATA_OUT_ENABLE && card_rd_w;

    // Open-drain style merge, any card pulling low asserts IRQ
    assign irq_merged_n_w = ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i;
    assign a2_irq_n_o     = IRQ_OUT_ENABLE ? irq_merged_n_w : 1'b1;

endmodule

`default_nettype wire

// ==== hw/bus_strobe_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_strobe_sync (
    input  wire  clk_pixel_w,
    input  wire  rst_n_i,
    input  wire  a2_phi1_i,
    input  wire  a2_q3_i,
    input  wire  a2_7m_i,
    output logic phi1_o,
    output logic phi0_o,
    output logic phi1_rise_o,
    output logic phi1_fall_o,
    output logic q3_rise_o,
    output logic q3_fall_o,
    output logic c7m_rise_o,
    output logic c7m_fall_o,
    output logic c14m_tick_o
);

    // Bit positions of the Apple clocks in the sync vectors
    localparam int NUM_CLK  = 3;
    localparam int IDX_PHI1 = 0;
    localparam int IDX_Q3   = 1;
    localparam int IDX_7M   = 2;

    logic [NUM_CLK-1:0] async_w;
    logic [NUM_CLK-1:0] meta_r;
    logic [NUM_CLK-1:0] sync_r;
    logic [NUM_CLK-1:0] hist_r;
    logic [NUM_CLK-1:0] rise_w;
    logic [NUM_CLK-1:0] fall_w;

    assign async_w[IDX_PHI1] = a2_phi1_i;
    assign async_w[IDX_Q3]   = a2_q3_i;
    assign async_w[IDX_7M]   = a2_7m_i;

    // Two flops for metastability, one more to remember the last level
    always_ff @(posedge clk_pixel_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_r <= '0;
            sync_r <= '0;
            hist_r <= '0;
        end else begin
            meta_r <= async_w;
            sync_r <= meta_r;
            hist_r <= sync_r;
        end
    end

    assign rise_w = sync_r & ~hist_r;
    assign fall_w = ~sync_r & hist_r;

    assign phi1_o = sync_r[IDX_PHI1];
    assign phi0_o = ~sync_r[IDX_PHI1];

    assign phi1_rise_o = rise_w[IDX_PHI1];
    assign phi1_fall_o = fall_w[IDX_PHI1];
    assign q3_rise_o   = rise_w[IDX_Q3];
    assign q3_fall_o   = fall_w[IDX_Q3];
    assign c7m_rise_o  = rise_w[IDX_7M];
    assign c7m_fall_o  = fall_w[IDX_7M];

    // Both 7M edges give the 14M rate
    assign c14m_tick_o = rise_w[IDX_7M] | fall_w[IDX_7M];

endmodule

`default_nettype wire

// ==== hw/power_on_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module power_on_timer #(
    parameter int HEARTBEAT_CYCLES = 5_000_000
) (
    input  wire  clk_pixel_w,
    input  wire  rst_n_i,
    input  wire  a2_reset_n_i,
    output logic device_reset_n_o,
    output logic system_reset_n_o,
    output logic heartbeat_o
);

    import a2card_pkg::*;

    // Counter must hold HEARTBEAT_CYCLES-1
    localparam int CNT_W = (HEARTBEAT_CYCLES > 1) ? $clog2(HEARTBEAT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HEARTBEAT_CYCLES - 1);

    logic [CNT_W-1:0] cnt_r;
    logic             wrap_w;
    logic             heartbeat_r;
    timer_state_e     state_r;

    assign wrap_w = (cnt_r == CNT_LAST);

    always_ff @(posedge clk_pixel_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_r       <= '0;
            heartbeat_r <= 1'b0;
            state_r     <= TMR_HOLD;
        end else if (wrap_w) begin
            cnt_r       <= '0;
            heartbeat_r <= ~heartbeat_r;
            // First wrap ends the hold, later wraps only blink the LED
            state_r     <= TMR_RUN;
        end else begin
            cnt_r <= cnt_r + 1'b1;
        end
    end

    assign device_reset_n_o = (state_r == TMR_RUN);

    // Apple II reset also resets the card logic
    assign system_reset_n_o = device_reset_n_o & a2_reset_n_i;

    assign heartbeat_o = heartbeat_r;

endmodule

`default_nettype wire

// ==== hw/a2card_pkg.sv ====
`default_nettype none

package a2card_pkg;

    // Apple II data bus
    localparam int BYTE_W = 8;

    // Video path
    localparam int RGB_W      = 8;
    localparam int SCREEN_Y_W = 10;

    // Audio path, the mixed sample shares its width with the sprite audio
    localparam int SAMPLE_W   = 16;
    localparam int MB_AUDIO_W = 10;

    // Scaling of the narrower sources into the 16-bit sample
    localparam int MB_SHIFT      = 5;
    localparam int SPEAKER_SHIFT = 13;

    // Card that answers the current read cycle
    typedef enum logic [1:0] {
        SRC_NONE         = 2'd0,
        SRC_SERIAL       = 2'd1,
        SRC_SPRITE       = 2'd2,
        SRC_MOCKINGBOARD = 2'd3
    } card_source_e;

    // Power-on timer, hold keeps the device in reset
    typedef enum logic {
        TMR_HOLD = 1'b0,
        TMR_RUN  = 1'b1
    } timer_state_e;

endpackage

`default_nettype wire
